// File: hdl/cp0_pkg.sv
package cp0_pkg;

    typedef logic [31:0] word_t;

    // coprocessor 0 register numbers, as seen in the rd field of mfc0/mtc0
    typedef enum logic [4:0] {
        BADVADDR = 5'd8,
        COUNT    = 5'd9,
        COMPARE  = 5'd11,
        STATUS   = 5'd12,
        CAUSE    = 5'd13,
        EPC      = 5'd14,
        CONFIG   = 5'd16
    } cp0_reg_e;

    // status fields
    localparam int STATUS_IE     = 0;
    localparam int STATUS_EXL    = 1;
    localparam int STATUS_IM_LO  = 8;
    localparam int STATUS_IM_HI  = 15;

    // cause fields
    localparam int CAUSE_EXC_LO  = 2;
    localparam int CAUSE_EXC_HI  = 6;
    localparam int CAUSE_IP_LO   = 8;
    localparam int CAUSE_IP_HI   = 15;
    localparam int CAUSE_BD      = 31;

    localparam int IP_WIDTH      = CAUSE_IP_HI - CAUSE_IP_LO + 1;
    localparam int SW_IP_WIDTH   = 2;
    localparam int HW_IP_WIDTH   = IP_WIDTH - SW_IP_WIDTH;

    // BEV set, everything else clear
    localparam word_t STATUS_RESET = 32'h0040_0000;
    // M bit set, kseg0 cacheable
    localparam word_t CONFIG_VALUE = 32'h8000_0003;

    localparam word_t EXC_VECTOR   = 32'hBFC0_0380;
    localparam word_t RESET_PC     = 32'hBFC0_0000;

    function automatic logic is_cp0_reg(logic [4:0] num);
        case (num)
            BADVADDR,
            COUNT,
            COMPARE,
            STATUS,
            CAUSE,
            EPC,
            CONFIG:  return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage

// File: hdl/exception_pkg.sv
package exception_pkg;

    typedef enum logic [4:0] {
        CODE_INT  = 5'd0,
        CODE_ADEL = 5'd4,
        CODE_ADES = 5'd5,
        CODE_SYS  = 5'd8,
        CODE_BP   = 5'd9,
        CODE_RI   = 5'd10,
        CODE_OV   = 5'd12
    } exccode_e;

    // fault flags of a retiring instruction, highest priority first
    localparam int NUM_FAULTS = 6;
    localparam int FAULT_ADEL = 0;
    localparam int FAULT_ADES = 1;
    localparam int FAULT_RI   = 2;
    localparam int FAULT_OV   = 3;
    localparam int FAULT_SYS  = 4;
    localparam int FAULT_BP   = 5;

    localparam exccode_e FAULT_CODE [NUM_FAULTS] = '{
        CODE_ADEL,
        CODE_ADES,
        CODE_RI,
        CODE_OV,
        CODE_SYS,
        CODE_BP
    };

    // address errors are the only codes that load BadVAddr
    function automatic logic is_addr_error(exccode_e code);
        return (code == CODE_ADEL) || (code == CODE_ADES);
    endfunction

endpackage

// File: hdl/cp0_apb_port.sv
module cp0_apb_port (
    input  logic               clk,
    input  logic               reset,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [31:0]        paddr,
    input  cp0_pkg::word_t     pwdata,
    output cp0_pkg::word_t     prdata,
    output logic               pready,
    output logic               pslverr,
    output logic               cwen,
    output cp0_pkg::cp0_reg_e  caddr,
    output cp0_pkg::cp0_reg_e  raddr,
    output cp0_pkg::word_t     cwdata,
    input  cp0_pkg::word_t     rdata
);
    import cp0_pkg::*;

    logic       access;
    logic [4:0] reg_num;
    logic       reg_ok;

    // register number sits in the word address bits
    assign reg_num = paddr[6:2];
    assign reg_ok  = is_cp0_reg(reg_num);

    // no wait states, every access phase completes
    assign access = psel & penable;
    assign pready = 1'b1;

    assign pslverr = access & ~reg_ok;

    // write strobe lasts exactly the one access cycle
    assign cwen   = access & pwrite & reg_ok;
    assign caddr  = cp0_reg_e'(reg_num);
    assign cwdata = pwdata;

    // read path is combinational through cp0
    assign raddr  = cp0_reg_e'(reg_num);

    always_comb begin
        if (access && !pwrite) begin
            prdata = rdata;
        end else begin
            prdata = '0;
        end
    end

    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (reset)
        penable |-> psel
    ) else $error("penable high without psel");

endmodule

// File: hdl/cp0.sv
module cp0 #(
    parameter int HW_INT_WIDTH = 6
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cwen,
    input  cp0_pkg::cp0_reg_e        caddr,
    input  cp0_pkg::cp0_reg_e        raddr,
    input  cp0_pkg::word_t           cwdata,
    output cp0_pkg::word_t           rdata,
    input  logic [HW_INT_WIDTH-1:0]  hw_int,
    input  logic                     exc_valid,
    input  logic                     exc_delay_slot,
    input  logic                     eret,
    input  exception_pkg::exccode_e  exc_code,
    input  cp0_pkg::word_t           exc_pc,
    input  cp0_pkg::word_t           exc_badvaddr,
    output cp0_pkg::word_t           status,
    output cp0_pkg::word_t           cause,
    output cp0_pkg::word_t           epc,
    output logic [7:0]               ip_pending
);
    import cp0_pkg::*;
    import exception_pkg::*;

    word_t    badvaddr_q;
    word_t    count_q;
    word_t    count_next;
    word_t    compare_q;
    word_t    status_q;
    word_t    epc_q;
    logic     cause_bd;
    logic [SW_IP_WIDTH-1:0] sw_ip;
    exccode_e exccode_q;
    logic     count_tick;
    logic     timer_int;
    logic     compare_wr;
    logic [HW_IP_WIDTH-1:0] hw_ip;

    // count advances on every other clock
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            count_tick <= 1'b0;
        end else begin
            count_tick <= ~count_tick;
        end
    end

    assign compare_wr = cwen && (caddr == COMPARE);

    always_comb begin
        count_next = count_q;
        if (cwen && caddr == COUNT) begin
            count_next = cwdata;
        end else if (count_tick) begin
            count_next = count_q + 32'd1;
        end
    end

    // timer fires when count moves onto compare, compare write acknowledges it
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            count_q   <= '0;
            timer_int <= 1'b0;
        end else begin
            count_q <= count_next;
            if (compare_wr) begin
                timer_int <= 1'b0;
            end else if (count_next == compare_q && count_next != count_q) begin
                timer_int <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            badvaddr_q <= '0;
            compare_q  <= '0;
            status_q   <= STATUS_RESET;
            epc_q      <= '0;
            cause_bd   <= 1'b0;
            sw_ip      <= '0;
            exccode_q  <= CODE_INT;
        end else begin
            if (cwen) begin
                case (caddr)
                    COMPARE: compare_q <= cwdata;
                    STATUS: begin
                        status_q[STATUS_IM_HI:STATUS_IM_LO] <= cwdata[STATUS_IM_HI:STATUS_IM_LO];
                        status_q[STATUS_EXL] <= cwdata[STATUS_EXL];
                        status_q[STATUS_IE]  <= cwdata[STATUS_IE];
                    end
                    CAUSE:   sw_ip <= cwdata[CAUSE_IP_LO +: SW_IP_WIDTH];
                    EPC:     epc_q <= cwdata;
                    default: ;
                endcase
            end

            // exception entry takes precedence over a same-cycle register write
            if (exc_valid) begin
                if (!status_q[STATUS_EXL]) begin
                    cause_bd <= exc_delay_slot;
                    epc_q    <= exc_delay_slot ? exc_pc - 32'd4 : exc_pc;
                end
                exccode_q <= exc_code;
                status_q[STATUS_EXL] <= 1'b1;
                if (is_addr_error(exc_code)) begin
                    badvaddr_q <= exc_badvaddr;
                end
            end

            if (eret) begin
                status_q[STATUS_EXL] <= 1'b0;
            end
        end
    end

    // external lines fill IP2 upward, unused lines read as zero
    always_comb begin
        hw_ip = '0;
        hw_ip[HW_INT_WIDTH-1:0] = hw_int;
    end

    // hardware and timer requests only, software bits come from cause
    assign ip_pending = {hw_ip[HW_IP_WIDTH-1] | timer_int, hw_ip[HW_IP_WIDTH-2:0], 2'b00};

    assign status = status_q;
    assign epc    = epc_q;
    assign cause  = {cause_bd, 15'b0, ip_pending | {6'b0, sw_ip}, 1'b0, exccode_q, 2'b00};

    always_comb begin
        case (raddr)
            BADVADDR: rdata = badvaddr_q;
            COUNT:    rdata = count_q;
            STATUS:   rdata = status;
            CAUSE:    rdata = cause;
            EPC:      rdata = epc_q;
            CONFIG:   rdata = CONFIG_VALUE;
            default:  rdata = '0;
        endcase
    end

    a_no_exc_with_eret: assert property (
        @(posedge clk) disable iff (reset)
        !(exc_valid && eret)
    ) else $error("exception and eret in the same cycle");

endmodule

// File: hdl/exception_unit.sv
module exception_unit #(
    parameter int HW_INT_WIDTH = 6
) (
    input  logic                     retire_valid,
    input  logic                     retire_delay_slot,
    input  logic                     retire_eret,
    input  cp0_pkg::word_t           retire_pc,
    input  cp0_pkg::word_t           retire_badvaddr,
    input  logic                     flag_adel,
    input  logic                     flag_ades,
    input  logic                     flag_sys,
    input  logic                     flag_bp,
    input  logic                     flag_ri,
    input  logic                     flag_ov,
    input  cp0_pkg::word_t           status,
    input  cp0_pkg::word_t           cause,
    input  logic [7:0]               ip_pending,
    output logic                     exc_valid,
    output logic                     exc_delay_slot,
    output logic                     eret,
    output exception_pkg::exccode_e  exc_code,
    output cp0_pkg::word_t           exc_pc,
    output cp0_pkg::word_t           exc_badvaddr,
    output logic                     redirect_exc,
    output logic                     redirect_eret
);
    import cp0_pkg::*;
    import exception_pkg::*;

    // IP7 is the timer and IP2 upward the connected external lines
    localparam logic [IP_WIDTH-1:0] LINE_MASK =
        8'h80 | (((8'h01 << HW_INT_WIDTH) - 8'h01) << SW_IP_WIDTH);

    logic [IP_WIDTH-1:0]   pending;
    logic                  int_req;
    logic [NUM_FAULTS-1:0] fault_vec;

    assign pending = (ip_pending & LINE_MASK) |
                     {6'b0, cause[CAUSE_IP_LO +: SW_IP_WIDTH]};

    assign int_req = status[STATUS_IE] && !status[STATUS_EXL] &&
                     |(pending & status[STATUS_IM_HI:STATUS_IM_LO]);

    always_comb begin
        fault_vec = '0;
        fault_vec[FAULT_ADEL] = flag_adel;
        fault_vec[FAULT_ADES] = flag_ades;
        fault_vec[FAULT_RI]   = flag_ri;
        fault_vec[FAULT_OV]   = flag_ov;
        fault_vec[FAULT_SYS]  = flag_sys;
        fault_vec[FAULT_BP]   = flag_bp;
    end

    // walk from lowest priority up so the highest set flag wins
    always_comb begin
        exc_code = CODE_INT;
        if (!int_req) begin
            for (int i = NUM_FAULTS - 1; i >= 0; i--) begin
                if (fault_vec[i]) begin
                    exc_code = FAULT_CODE[i];
                end
            end
        end
    end

    assign exc_valid      = retire_valid && (int_req || |fault_vec);
    assign exc_pc         = retire_pc;
    assign exc_delay_slot = retire_delay_slot;
    assign exc_badvaddr   = retire_badvaddr;

    // a faulting eret is just another exception
    assign eret = retire_valid && retire_eret && !exc_valid;

    assign redirect_exc  = exc_valid;
    assign redirect_eret = eret;

endmodule

// File: hdl/pc_select.sv
module pc_select (
    input  logic            clk,
    input  logic            reset,
    input  logic            fetch_ready,
    input  logic            redirect_exc,
    input  logic            redirect_eret,
    input  cp0_pkg::word_t  epc,
    output cp0_pkg::word_t  fetch_pc
);
    import cp0_pkg::*;

    word_t pc_q;

    // redirects win over back-pressure
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            pc_q <= RESET_PC;
        end else if (redirect_exc) begin
            pc_q <= EXC_VECTOR;
        end else if (redirect_eret) begin
            pc_q <= epc;
        end else if (fetch_ready) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign fetch_pc = pc_q;

endmodule

// File: hdl/cp0_subsystem.sv
module cp0_subsystem #(
    parameter int HW_INT_WIDTH = 6
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [31:0]              paddr,
    input  cp0_pkg::word_t           pwdata,
    output cp0_pkg::word_t           prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  logic                     retire_valid,
    input  cp0_pkg::word_t           retire_pc,
    input  logic                     retire_delay_slot,
    input  cp0_pkg::word_t           retire_badvaddr,
    input  logic                     flag_adel,
    input  logic                     flag_ades,
    input  logic                     flag_sys,
    input  logic                     flag_bp,
    input  logic                     flag_ri,
    input  logic                     flag_ov,
    input  logic                     retire_eret,
    input  logic [HW_INT_WIDTH-1:0]  hw_int,
    input  logic                     fetch_ready,
    output cp0_pkg::word_t           fetch_pc
);
    import cp0_pkg::*;
    import exception_pkg::*;

    logic       cwen;
    cp0_reg_e   caddr;
    cp0_reg_e   raddr;
    word_t      cwdata;
    word_t      rdata;
    word_t      status;
    word_t      cause;
    word_t      epc;
    logic [7:0] ip_pending;
    logic       exc_valid;
    logic       exc_delay_slot;
    logic       eret;
    exccode_e   exc_code;
    word_t      exc_pc;
    word_t      exc_badvaddr;
    logic       redirect_exc;
    logic       redirect_eret;

    cp0_apb_port i_cp0_apb_port (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cwen    (cwen),
        .caddr   (caddr),
        .raddr   (raddr),
        .cwdata  (cwdata),
        .rdata   (rdata)
    );

    cp0 #(
        .HW_INT_WIDTH (HW_INT_WIDTH)
    ) i_cp0 (
        .clk            (clk),
        .reset          (reset),
        .cwen           (cwen),
        .caddr          (caddr),
        .raddr          (raddr),
        .cwdata         (cwdata),
        .rdata          (rdata),
        .hw_int         (hw_int),
        .exc_valid      (exc_valid),
        .exc_delay_slot (exc_delay_slot),
        .eret           (eret),
        .exc_code       (exc_code),
        .exc_pc         (exc_pc),
        .exc_badvaddr   (exc_badvaddr),
        .status         (status),
        .cause          (cause),
        .epc            (epc),
        .ip_pending     (ip_pending)
    );

    exception_unit #(
        .HW_INT_WIDTH (HW_INT_WIDTH)
    ) i_exception_unit (
        .retire_valid      (retire_valid),
        .retire_delay_slot (retire_delay_slot),
        .retire_eret       (retire_eret),
        .retire_pc         (retire_pc),
        .retire_badvaddr   (retire_badvaddr),
        .flag_adel         (flag_adel),
        .flag_ades         (flag_ades),
        .flag_sys          (flag_sys),
        .flag_bp           (flag_bp),
        .flag_ri           (flag_ri),
        .flag_ov           (flag_ov),
        .status            (status),
        .cause             (cause),
        .ip_pending        (ip_pending),
        .exc_valid         (exc_valid),
        .exc_delay_slot    (exc_delay_slot),
        .eret              (eret),
        .exc_code          (exc_code),
        .exc_pc            (exc_pc),
        .exc_badvaddr      (exc_badvaddr),
        .redirect_exc      (redirect_exc),
        .redirect_eret     (redirect_eret)
    );

    pc_select i_pc_select (
        .clk           (clk),
        .reset         (reset),
        .fetch_ready   (fetch_ready),
        .redirect_exc  (redirect_exc),
        .redirect_eret (redirect_eret),
        .epc           (epc),
        .fetch_pc      (fetch_pc)
    );

endmodule

// File: verif/cp0_tb.sv
module cp0_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import cp0_pkg::*;
    import exception_pkg::*;

    localparam int HW_INT_WIDTH = 6;
    localparam int APB_TIMEOUT  = 16;
    localparam int WAIT_TIMEOUT = 200;

    logic                     clk;
    logic                     reset;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [31:0]              paddr;
    word_t                    pwdata;
    word_t                    prdata;
    logic                     pready;
    logic                     pslverr;
    logic                     retire_valid;
    word_t                    retire_pc;
    logic                     retire_delay_slot;
    word_t                    retire_badvaddr;
    logic                     flag_adel;
    logic                     flag_ades;
    logic                     flag_sys;
    logic                     flag_bp;
    logic                     flag_ri;
    logic                     flag_ov;
    logic                     retire_eret;
    logic [HW_INT_WIDTH-1:0]  hw_int;
    logic                     fetch_ready;
    word_t                    fetch_pc;

    // reference model of the CP0 state
    word_t       m_status;
    word_t       m_epc;
    word_t       m_badvaddr;
    logic        m_bd;
    logic [1:0]  m_sw_ip;
    exccode_e    m_exccode;
    logic        m_timer;
    word_t       m_pc;
    word_t       count_base;
    int          count_cycle;
    int          cycles;
    int          sample_cycle;
    logic        exp_redirect_exc;
    logic        exp_redirect_eret;
    logic [31:0] rng_state = 32'd46;

    cp0_subsystem #(
        .HW_INT_WIDTH (HW_INT_WIDTH)
    ) i_cp0_subsystem (
        .clk               (clk),
        .reset             (reset),
        .psel              (psel),
        .penable           (penable),
        .pwrite            (pwrite),
        .paddr             (paddr),
        .pwdata            (pwdata),
        .prdata            (prdata),
        .pready            (pready),
        .pslverr           (pslverr),
        .retire_valid      (retire_valid),
        .retire_pc         (retire_pc),
        .retire_delay_slot (retire_delay_slot),
        .retire_badvaddr   (retire_badvaddr),
        .flag_adel         (flag_adel),
        .flag_ades         (flag_ades),
        .flag_sys          (flag_sys),
        .flag_bp           (flag_bp),
        .flag_ri           (flag_ri),
        .flag_ov           (flag_ov),
        .retire_eret       (retire_eret),
        .hw_int            (hw_int),
        .fetch_ready       (fetch_ready),
        .fetch_pc          (fetch_pc)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (!reset) begin
            cycles++;
        end
    end

    // fetch PC follows the redirects the model expects
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            m_pc = RESET_PC;
        end else if (exp_redirect_exc) begin
            m_pc = EXC_VECTOR;
        end else if (exp_redirect_eret) begin
            m_pc = m_epc;
        end else if (fetch_ready) begin
            m_pc = m_pc + 32'd4;
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR at %0t: %s = 0x%08h, expected 0x%08h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_code(input string name, input exccode_e got, input exccode_e exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR at %0t: %s = %0d, expected %0d",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_pc();
        check_word("fetch_pc", fetch_pc, m_pc);
    endtask

    function automatic logic is_defined(input logic [4:0] num);
        return num inside {5'd8, 5'd9, 5'd11, 5'd12, 5'd13, 5'd14, 5'd16};
    endfunction

    function automatic word_t expected_cause();
        return {m_bd, 15'b0, m_timer | hw_int[5], hw_int[4:0], m_sw_ip,
                1'b0, m_exccode, 2'b00};
    endfunction

    function automatic word_t expected_read(input logic [4:0] num);
        case (num)
            BADVADDR: return m_badvaddr;
            STATUS:   return m_status;
            CAUSE:    return expected_cause();
            EPC:      return m_epc;
            CONFIG:   return CONFIG_VALUE;
            default:  return '0;
        endcase
    endfunction

    function automatic word_t count_estimate();
        return count_base + word_t'((cycles - count_cycle) / 2);
    endfunction

    // priority falls from ADEL through ADES, RI, OV and SYS down to BP
    function automatic exccode_e fault_code(input logic [5:0] faults);
        if (faults[0]) begin
            return CODE_ADEL;
        end else if (faults[1]) begin
            return CODE_ADES;
        end else if (faults[2]) begin
            return CODE_RI;
        end else if (faults[3]) begin
            return CODE_OV;
        end else if (faults[4]) begin
            return CODE_SYS;
        end
        return CODE_BP;
    endfunction

    task automatic apply_write(input logic [4:0] num, input word_t data);
        case (num)
            COUNT: begin
                count_base  = data;
                count_cycle = cycles;
            end
            COMPARE: m_timer = 1'b0;
            STATUS:  m_status = (m_status & ~32'h0000_FF03) | (data & 32'h0000_FF03);
            CAUSE:   m_sw_ip = data[9:8];
            EPC:     m_epc = data;
            default: ;
        endcase
    endtask

    // entered and left on a falling edge
    task automatic apb_access(input logic write, input logic [4:0] num, input word_t wdata,
                              output word_t rdata, output logic err);
        int waited;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = {25'b0, num, 2'b00};
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        waited  = 0;
        #1;
        while (pready !== 1'b1) begin
            if (waited >= APB_TIMEOUT) begin
                report_failure("APB slave never raised pready");
            end
            @(negedge clk);
            #1;
            waited++;
        end
        rdata        = prdata;
        err          = pslverr;
        sample_cycle = cycles;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input logic [4:0] num, input word_t data);
        word_t unused;
        logic  err;
        apb_access(1'b1, num, data, unused, err);
        check_word("pslverr", {31'b0, err}, {31'b0, !is_defined(num)});
        apply_write(num, data);
    endtask

    task automatic check_count(input word_t got);
        word_t est;
        est = count_base + word_t'((sample_cycle - count_cycle) / 2);
        // the half-rate tick phase leaves one count of slack
        if (got == est + 32'd1 || got == est - 32'd1) begin
            est = got;
        end
        check_word("prdata(count)", got, est);
    endtask

    task automatic read_check(input logic [4:0] num);
        word_t data;
        logic  err;
        apb_access(1'b0, num, '0, data, err);
        check_word("pslverr", {31'b0, err}, {31'b0, !is_defined(num)});
        if (num == COUNT) begin
            check_count(data);
        end else begin
            if (num == CAUSE) begin
                check_code("cause.exccode", exccode_e'(data[6:2]), m_exccode);
            end
            check_word($sformatf("prdata(reg %0d)", num), data, expected_read(num));
        end
    endtask

    task automatic retire(input logic [5:0] faults, input logic eret_bit, input word_t pc,
                          input logic ds, input word_t bva);
        logic [7:0] pending;
        logic       int_taken;
        logic       exc;
        exccode_e   code;
        pending   = {m_timer | hw_int[5], hw_int[4:0], m_sw_ip};
        int_taken = m_status[STATUS_IE] && !m_status[STATUS_EXL] &&
                    ((pending & m_status[15:8]) != 8'h00);
        exc       = int_taken || (faults != 6'b0);
        code      = int_taken ? CODE_INT : fault_code(faults);
        retire_valid      = 1'b1;
        retire_pc         = pc;
        retire_delay_slot = ds;
        retire_badvaddr   = bva;
        flag_adel         = faults[0];
        flag_ades         = faults[1];
        flag_ri           = faults[2];
        flag_ov           = faults[3];
        flag_sys          = faults[4];
        flag_bp           = faults[5];
        retire_eret       = eret_bit;
        exp_redirect_exc  = exc;
        exp_redirect_eret = eret_bit && !exc;
        @(negedge clk);
        retire_valid      = 1'b0;
        {flag_adel, flag_ades, flag_ri, flag_ov, flag_sys, flag_bp} = 6'b0;
        retire_eret       = 1'b0;
        exp_redirect_exc  = 1'b0;
        exp_redirect_eret = 1'b0;
        check_pc();
        if (exc) begin
            // EPC and BD only load on the first exception
            if (!m_status[STATUS_EXL]) begin
                m_bd  = ds;
                m_epc = ds ? pc - 32'd4 : pc;
            end
            m_exccode = code;
            m_status[STATUS_EXL] = 1'b1;
            if (code == CODE_ADEL || code == CODE_ADES) begin
                m_badvaddr = bva;
            end
        end else if (eret_bit) begin
            m_status[STATUS_EXL] = 1'b0;
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [4:0]  num;
        logic [5:0]  faults;
        word_t       data;
        word_t       target;
        logic        err;
        int          waited;

        $timeformat(-9, 0, " ns", 0);
        clk = 1'b0;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        retire_valid = 1'b0;
        retire_pc = '0;
        retire_delay_slot = 1'b0;
        retire_badvaddr = '0;
        {flag_adel, flag_ades, flag_ri, flag_ov, flag_sys, flag_bp} = 6'b0;
        retire_eret = 1'b0;
        hw_int = '0;
        fetch_ready = 1'b1;
        m_status = STATUS_RESET;
        m_epc = '0;
        m_badvaddr = '0;
        m_bd = 1'b0;
        m_sw_ip = '0;
        m_exccode = CODE_INT;
        m_timer = 1'b0;
        count_base = '0;
        count_cycle = 0;
        cycles = 0;
        sample_cycle = 0;
        exp_redirect_exc = 1'b0;
        exp_redirect_eret = 1'b0;

        repeat (8) @(negedge clk);
        reset = 1'b0;
        check_pc();
        check_word("pslverr", {31'b0, pslverr}, '0);
        read_check(STATUS);
        read_check(CAUSE);

        // every register number first and then random ones
        for (int i = 0; i < 96; i++) begin
            r = next_random();
            num = (i < 32) ? 5'(i) : r[4:0];
            write_reg(num, next_random());
            read_check(num);
        end

        // count runs at half the clock rate
        write_reg(COUNT, 32'h0000_1000);
        repeat (17) @(negedge clk);
        read_check(COUNT);
        apb_access(1'b0, COUNT, '0, data, err);
        check_word("pslverr", {31'b0, err}, '0);
        check_count(data);
        count_base  = data;
        count_cycle = sample_cycle;
        target = data + 32'd12;
        write_reg(COMPARE, target);
        read_check(CAUSE);
        waited = 0;
        while (count_estimate() <= target) begin
            if (waited >= WAIT_TIMEOUT) begin
                report_failure("Count never reached the Compare value");
            end
            @(negedge clk);
            waited++;
        end
        m_timer = 1'b1;
        read_check(CAUSE);
        write_reg(COMPARE, target + 32'h1000_0000);
        read_check(CAUSE);

        // single faults with every third one nested while EXL is still set
        for (int i = 0; i < 30; i++) begin
            if (i % 3 != 2) begin
                write_reg(STATUS, 32'h0);
            end
            r = next_random();
            faults = 6'b1 << (r % 6);
            retire(faults, 1'b0, next_random() & ~32'h3, r[8], next_random());
            read_check(EPC);
            read_check(CAUSE);
            read_check(BADVADDR);
            read_check(STATUS);
        end

        // several faults together and some on an eret
        for (int i = 0; i < 20; i++) begin
            write_reg(STATUS, 32'h0);
            r = next_random();
            faults = (r[5:0] == 6'b0) ? 6'b100000 : r[5:0];
            retire(faults, r[7], next_random() & ~32'h3, r[8], next_random());
            read_check(CAUSE);
            read_check(BADVADDR);
        end

        for (int i = 0; i < 4; i++) begin
            write_reg(STATUS, 32'h0);
            r = next_random();
            retire(6'b000100, 1'b0, next_random() & ~32'h3, r[0], '0);
            retire(6'b0, 1'b1, next_random(), 1'b0, '0);
            // back-pressure holds the PC
            for (int k = 0; k < 16; k++) begin
                r = next_random();
                fetch_ready = r[0];
                @(negedge clk);
                check_pc();
            end
            fetch_ready = 1'b1;
            read_check(STATUS);
        end

        // interrupts with IE set and random lines, masks and EXL
        for (int i = 0; i < 32; i++) begin
            r = next_random();
            hw_int = r[5:0];
            write_reg(STATUS, {16'b0, r[15:8], 6'b0, r[16], 1'b1});
            write_reg(CAUSE, next_random());
            retire(6'b0, 1'b0, next_random() & ~32'h3, r[17], next_random());
            read_check(CAUSE);
            read_check(STATUS);
            read_check(EPC);
        end
        hw_int = '0;

        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin
        #1_000_000;
        report_failure("simulation ran past its time limit");
    end

endmodule

// File: cp0_subsystem.f
hdl/cp0_pkg.sv
hdl/exception_pkg.sv
hdl/cp0_apb_port.sv
hdl/cp0.sv
hdl/exception_unit.sv
hdl/pc_select.sv
hdl/cp0_subsystem.sv
verif/cp0_tb.sv

// File: Bender.yml
package:
  name: cp0_subsystem

sources:
  - files:
      - hdl/cp0_pkg.sv
      - hdl/exception_pkg.sv
      - hdl/cp0_apb_port.sv
      - hdl/cp0.sv
      - hdl/exception_unit.sv
      - hdl/pc_select.sv
      - hdl/cp0_subsystem.sv
  - target: test
    files:
      - verif/cp0_tb.sv
